/* vlog.f */
+incdir+include
verilog/cn_pkg.sv
verilog/state_ram_if.sv
verilog/node_state_ram.sv
verilog/cn_access_pipe.sv
verilog/cn_extract.sv
verilog/cn_min_update.sv
verilog/cn_top.sv
bench/cn_tb.sv

/* Makefile */
# Verilator build and run of the check-node testbench

VERILATOR ?= verilator
TOP       ?= cn_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(OBJ_DIR)

/* include/cn_model.svh */
// reference model of the node records, included inside the testbench module
// the including scope must import cn_pkg and call predict_access once per access
`ifndef CN_MODEL_SVH
`define CN_MODEL_SVH

cn_state_t model_rec [NODE_COUNT];

// signed-integer view of the ones'-complement subtraction
function automatic llr_t ones_sub_sat(input llr_t a, input llr_t b);
  int   va;
  int   vb;
  int   diff;
  int   mag;
  logic sign;
  va   = a[LLR_WIDTH-1] ? -int'(a[MAG_WIDTH-1:0]) : int'(a[MAG_WIDTH-1:0]);
  vb   = b[LLR_WIDTH-1] ? -int'(b[MAG_WIDTH-1:0]) : int'(b[MAG_WIDTH-1:0]);
  diff = va - vb;
  // a zero result keeps the sign of a
  sign = (diff > 0) ? 1'b0 : (diff < 0) ? 1'b1 : a[LLR_WIDTH-1];
  mag  = (diff < 0) ? -diff : diff;
  if (mag > (1 << (MAG_WIDTH - 1)) - 1)
    mag = (1 << (MAG_WIDTH - 1)) - 1;
  return {sign, mag_t'(mag)};
endfunction

function automatic void clear_record(input node_addr_t addr);
  model_rec[addr] = '0;
endfunction

// returns the expected cn_msg and updates the record as the write-back would
function automatic llr_t predict_access(input node_addr_t addr, input logic we,
                                        input llr_t msg, input logic iteration,
                                        input logic first_half, input logic first_iteration);
  cn_state_t r;
  cn_state_t n;
  logic      new_iter;
  logic      sgn;
  mag_t      off_mag;
  mag_t      fmag;
  llr_t      fixed;
  llr_t      result;
  r        = model_rec[addr];
  new_iter = r.iter != iteration;
  if (new_iter || (!first_half && !r.up))
    r.count = '0;
  sgn     = (r.count < MAX_DEGREE) ? r.signs[r.count] : 1'b0;
  result  = {r.sign_result ^ sgn, (r.count == r.leastpos) ? r.nextleast : r.least};
  off_mag = (r.count == r.last_leastpos) ? r.last_nextleast : r.last_least;
  fixed   = ones_sub_sat(msg, first_iteration ? llr_t'(0)
                                              : llr_t'({r.last_sign_result ^ sgn, off_mag}));
  fmag    = fixed[MAG_WIDTH-1:0];
  n       = r;
  n.iter  = iteration;
  n.up    = ~first_half;
  n.count = r.count + 1'b1;
  if (we)
  begin
    if (r.count < MAX_DEGREE)
      n.signs[r.count] = fixed[LLR_WIDTH-1];
    if (new_iter || fmag < r.least)
    begin
      n.leastpos = r.count;
      n.least    = fmag;
    end
    if (new_iter)
      n.nextleast = '1;
    else if (fmag < r.least)
      n.nextleast = r.least;
    else if (fmag <= r.nextleast)
      n.nextleast = fmag;
    n.sign_result = new_iter ? fixed[LLR_WIDTH-1] : r.sign_result ^ fixed[LLR_WIDTH-1];
  end
  if (!first_half)
  begin
    n.last_sign_result = r.sign_result;
    n.last_leastpos    = r.leastpos;
    n.last_least       = r.least;
    n.last_nextleast   = r.nextleast;
  end
  model_rec[addr] = n;
  return result;
endfunction

`endif

/* bench/cn_tb.sv */
// drives four check nodes in rotation, each revisited every 8 cycles
// all 128 records are cleared first since the state RAM starts undefined
module cn_tb
  import cn_pkg::*;
();

  localparam int MAG_TIES  = 0;
  localparam int MAG_LARGE = 1;
  localparam int MAG_FULL  = 2;
  localparam int ROUNDS    = 4;
  // two cycles per access slot, plus clears and quiet gaps
  localparam int PLANNED_ACCESSES = ROUNDS * 2 * MAX_DEGREE * 4;
  localparam int WATCHDOG_TIME    = PLANNED_ACCESSES * 2 * 20 + (NODE_COUNT + 400) * 20;

  logic       clk;
  logic       rst;
  logic       iteration;
  logic       first_half;
  logic       first_iteration;
  logic       cn_we;
  logic       cn_rd;
  node_addr_t node_addr;
  llr_t       sh_msg;
  logic       node_clear;
  node_addr_t node_clear_addr;
  llr_t       cn_msg;

  logic [15:0] lfsr_state;
  llr_t        exp_q [$];
  logic [3:0]  rd_hist;
  int          checks;
  int          mismatches;
  int          other_errors;

  `include "cn_model.svh"

  cn_top uut (
    .clk             (clk),
    .rst             (rst),
    .iteration       (iteration),
    .first_half      (first_half),
    .first_iteration (first_iteration),
    .cn_we           (cn_we),
    .cn_rd           (cn_rd),
    .node_addr       (node_addr),
    .sh_msg          (sh_msg),
    .node_clear      (node_clear),
    .node_clear_addr (node_clear_addr),
    .cn_msg          (cn_msg)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // random source and stimulus helpers
  // ----------------------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  // small magnitudes give many ties, large ones force saturation
  function automatic llr_t pick_msg(input int mode);
    logic sgn;
    mag_t mag;
    sgn = (take_bits(1) != 0);
    case (mode)
      MAG_TIES:  mag = mag_t'(take_bits(2));
      MAG_LARGE: mag = {1'b1, 4'(take_bits(4))};
      default:   mag = mag_t'(take_bits(5));
    endcase
    return {sgn, mag};
  endfunction

  task automatic check_llr(input string name, input llr_t got, input llr_t expected);
    checks++;
    if (got !== expected)
    begin
      mismatches++;
      $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic quiet_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
      cn_we = 1'b0;
      cn_rd = 1'b0;
    end
  endtask

  task automatic clear_nodes(input int count);
    for (int i = 0; i < count; i++)
    begin
      @(posedge clk);
      #2;
      node_clear      = 1'b1;
      node_clear_addr = node_addr_t'(i);
      clear_record(node_addr_t'(i));
    end
    @(posedge clk);
    #2;
    node_clear = 1'b0;
  endtask

  task automatic drive_access(input int node, input logic we, input int mode);
    llr_t msg;
    llr_t expected;
    msg = pick_msg(mode);
    @(posedge clk);
    #2;
    cn_we     = we;
    cn_rd     = ~we;
    node_addr = node_addr_t'(node);
    sh_msg    = msg;
    expected  = predict_access(node_addr_t'(node), we, msg, iteration, first_half,
                               first_iteration);
    if (!we)
      exp_q.push_back(expected);
  endtask

  // four nodes back to back, then a gap so each node rests 8 cycles
  task automatic run_half(input int degree, input logic we, input int mode);
    for (int step = 0; step < degree; step++)
    begin
      for (int node = 0; node < 4; node++)
        drive_access(node, we, mode);
      quiet_cycles(4);
    end
  endtask

  task automatic run_round(input logic it, input logic first_it, input int mode);
    int degree;
    degree          = 2 + (take_bits(5) % 29);
    iteration       = it;
    first_iteration = first_it;
    first_half      = 1'b1;
    run_half(degree, 1'b1, mode);
    quiet_cycles(6);
    first_half = 1'b0;
    run_half(degree, 1'b0, mode);
    quiet_cycles(6);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    rst             = 1'b1;
    iteration       = 1'b0;
    first_half      = 1'b1;
    first_iteration = 1'b1;
    cn_we           = 1'b0;
    cn_rd           = 1'b0;
    node_addr       = '0;
    sh_msg          = '0;
    node_clear      = 1'b0;
    node_clear_addr = '0;
    lfsr_state      = 16'd55;
    checks          = 0;
    mismatches      = 0;
    other_errors    = 0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    clear_nodes(NODE_COUNT);
    run_round(1'b1, 1'b1, MAG_TIES);
    run_round(1'b0, 1'b0, MAG_LARGE);
    run_round(1'b1, 1'b0, MAG_FULL);
    // restart the four nodes so the stored iteration bit drops back to zero
    clear_nodes(4);
    run_round(1'b1, 1'b1, MAG_FULL);
    quiet_cycles(8);
    if (exp_q.size() != 0)
    begin
      other_errors++;
      $display("error: %0d expected read results were never produced", exp_q.size());
    end
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
             other_errors);
    if (mismatches == 0 && other_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // cn_msg is registered on the third edge after the read is sampled
  initial
  begin
    rd_hist = '0;
    forever
    begin
      @(posedge clk);
      rd_hist = {rd_hist[2:0], cn_rd};
      @(negedge clk);
      if (rd_hist[3])
      begin
        if (exp_q.size() == 0)
        begin
          other_errors++;
          $display("error at %0t: read result with no expected value queued", $time);
        end
        else
          check_llr("cn_msg", cn_msg, exp_q.pop_front());
      end
    end
  end

  initial
  begin
    #(WATCHDOG_TIME);
    $display("error: watchdog expired after %0d time units", WATCHDOG_TIME);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* verilog/cn_top.sv */
// min-sum check node for 128 nodes of degree up to 30
// same node may only be accessed again six cycles after its last access
// levels stay stable for five cycles after an access, clear only when idle
module cn_top
  import cn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       iteration,
  input  logic       first_half,
  input  logic       first_iteration,
  input  logic       cn_we,
  input  logic       cn_rd,
  input  node_addr_t node_addr,
  input  llr_t       sh_msg,
  input  logic       node_clear,
  input  node_addr_t node_clear_addr,
  output llr_t       cn_msg
);

  state_ram_if ram_bus ();

  logic      we_aligned;
  logic      access_aligned;
  llr_t      msg_aligned;
  cn_state_t old_state;
  llr_t      fixed_msg;
  logic      start_over;
  logic      we_fixed;

  node_state_ram u_ram (
    .clk             (clk),
    .rst             (rst),
    .node_clear      (node_clear),
    .node_clear_addr (node_clear_addr),
    .ram             (ram_bus.ram)
  );

  cn_access_pipe u_pipe (
    .clk            (clk),
    .rst            (rst),
    .cn_we          (cn_we),
    .cn_rd          (cn_rd),
    .node_addr      (node_addr),
    .sh_msg         (sh_msg),
    .we_aligned     (we_aligned),
    .access_aligned (access_aligned),
    .msg_aligned    (msg_aligned),
    .ram            (ram_bus.addr)
  );

  cn_extract u_extract (
    .clk             (clk),
    .rst             (rst),
    .iteration       (iteration),
    .first_half      (first_half),
    .first_iteration (first_iteration),
    .we_aligned      (we_aligned),
    .access_aligned  (access_aligned),
    .msg_aligned     (msg_aligned),
    .ram             (ram_bus.rdata),
    .cn_msg          (cn_msg),
    .old_state       (old_state),
    .fixed_msg       (fixed_msg),
    .start_over      (start_over),
    .we_fixed        (we_fixed)
  );

  cn_min_update u_update (
    .clk        (clk),
    .rst        (rst),
    .iteration  (iteration),
    .first_half (first_half),
    .old_state  (old_state),
    .fixed_msg  (fixed_msg),
    .start_over (start_over),
    .we_fixed   (we_fixed),
    .ram        (ram_bus.wdata)
  );

endmodule

/* verilog/cn_min_update.sv */
// builds the record written back to the state RAM, one register stage
// a new iteration seeds least with the message and nextleast with all ones
module cn_min_update
  import cn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       iteration,
  input  logic       first_half,
  input  cn_state_t  old_state,
  input  llr_t       fixed_msg,
  input  logic       start_over,
  input  logic       we_fixed,
  state_ram_if.wdata ram
);

  mag_t      fixed_mag;
  logic      fixed_sign;
  logic      winner;
  logic      runner_up;
  cn_state_t next_rec;
  cn_state_u new_word;

  assign fixed_mag  = fixed_msg[MAG_WIDTH-1:0];
  assign fixed_sign = fixed_msg[LLR_WIDTH-1];

  // ties with least go to nextleast
  assign winner    = fixed_mag < old_state.least;
  assign runner_up = ~winner & (fixed_mag <= old_state.nextleast);

  // ----------------------------------------------------------------------
  // next record
  // ----------------------------------------------------------------------
  always_comb
  begin
    next_rec       = old_state;
    next_rec.iter  = iteration;
    next_rec.up    = ~first_half;
    next_rec.count = old_state.count + 1'b1;

    if (we_fixed)
    begin
      if (old_state.count < MAX_DEGREE)
        next_rec.signs[old_state.count] = fixed_sign;

      if (winner || start_over)
      begin
        next_rec.leastpos = old_state.count;
        next_rec.least    = fixed_mag;
      end

      if (start_over)
        next_rec.nextleast = '1;
      else if (winner)
        next_rec.nextleast = old_state.least;
      else if (runner_up)
        next_rec.nextleast = fixed_mag;

      if (start_over)
        next_rec.sign_result = fixed_sign;
      else
        next_rec.sign_result = old_state.sign_result ^ fixed_sign;
    end

    // upstream half keeps the downstream results for the next correction
    if (!first_half)
    begin
      next_rec.last_sign_result = old_state.sign_result;
      next_rec.last_leastpos    = old_state.leastpos;
      next_rec.last_least       = old_state.least;
      next_rec.last_nextleast   = old_state.nextleast;
    end
  end

  always_ff @(posedge clk, posedge rst)
  begin
    if (rst)
      new_word.raw <= '0;
    else
      new_word.rec <= next_rec;
  end

  assign ram.wr_data = new_word;

endmodule

/* verilog/cn_extract.sv */
// registers the node record, then forms the outgoing message and the corrected
// incoming message; cn_msg only changes on reads and holds in between
module cn_extract
  import cn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       iteration,
  input  logic       first_half,
  input  logic       first_iteration,
  input  logic       we_aligned,
  input  logic       access_aligned,
  input  llr_t       msg_aligned,
  state_ram_if.rdata ram,
  output llr_t       cn_msg,
  output cn_state_t  old_state,
  output llr_t       fixed_msg,
  output logic       start_over,
  output logic       we_fixed
);

  cn_state_t stored;
  logic      restart_iter;
  logic      restart_up;
  cn_state_t st0;
  llr_t      msg0;
  logic      we0;
  logic      rd0;
  logic      start_over0;
  logic      cur_sign;
  mag_t      out_mag;
  mag_t      off_mag;
  llr_t      offset;

  // a - b in ones'-complement, magnitude saturates one bit short of full width
  function automatic llr_t sub_saturate(input llr_t a, input llr_t b);
    mag_t               a_mag;
    mag_t               b_mag;
    logic [MAG_WIDTH:0] span;
    logic               b_big;
    logic               sign;
    mag_t               mag;
    a_mag = a[MAG_WIDTH-1:0];
    b_mag = b[MAG_WIDTH-1:0];
    b_big = a_mag < b_mag;
    sign  = b_big ? ~b[LLR_WIDTH-1] : a[LLR_WIDTH-1];
    if (a[LLR_WIDTH-1] != b[LLR_WIDTH-1])
      span = {1'b0, a_mag} + {1'b0, b_mag};
    else if (b_big)
      span = {1'b0, b_mag - a_mag};
    else
      span = {1'b0, a_mag - b_mag};
    if (|span[MAG_WIDTH:MAG_WIDTH-1])
      mag = {1'b0, {(MAG_WIDTH-1){1'b1}}};
    else
      mag = span[MAG_WIDTH-1:0];
    return {sign, mag};
  endfunction

  assign stored       = ram.rd_data.rec;
  assign restart_iter = stored.iter != iteration;
  // upstream half starts a fresh count
  assign restart_up   = ~first_half & ~stored.up;

  // ----------------------------------------------------------------------
  // stage 0: decoded record
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    st0       <= stored;
    st0.count <= (restart_iter | restart_up) ? '0 : stored.count;
    msg0      <= msg_aligned;
  end

  always_ff @(posedge clk, posedge rst)
  begin
    if (rst)
    begin
      we0         <= 1'b0;
      rd0         <= 1'b0;
      start_over0 <= 1'b0;
    end
    else
    begin
      we0         <= we_aligned;
      rd0         <= access_aligned & ~we_aligned;
      start_over0 <= restart_iter;
    end
  end

  // ----------------------------------------------------------------------
  // stage 1: outgoing message and previous-message correction
  // ----------------------------------------------------------------------
  assign cur_sign = (st0.count < MAX_DEGREE) ? st0.signs[st0.count] : 1'b0;
  assign out_mag  = (st0.count == st0.leastpos) ? st0.nextleast : st0.least;
  assign off_mag  = (st0.count == st0.last_leastpos) ? st0.last_nextleast : st0.last_least;
  // nothing to take back in the first iteration
  assign offset   = first_iteration ? '0 : {st0.last_sign_result ^ cur_sign, off_mag};

  always_ff @(posedge clk, posedge rst)
  begin
    if (rst)
    begin
      cn_msg     <= '0;
      start_over <= 1'b0;
      we_fixed   <= 1'b0;
    end
    else
    begin
      if (rd0)
        cn_msg <= {st0.sign_result ^ cur_sign, out_mag};
      start_over <= start_over0;
      we_fixed   <= we0;
    end
  end

  always_ff @(posedge clk)
  begin
    fixed_msg <= sub_saturate(msg0, offset);
    old_state <= st0;
  end

endmodule

/* verilog/cn_access_pipe.sv */
// delays the access strobes, address and message to meet the RAM and write-back
// no same-address forwarding, so a node must rest six cycles between accesses
module cn_access_pipe
  import cn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cn_we,
  input  logic       cn_rd,
  input  node_addr_t node_addr,
  input  llr_t       sh_msg,
  output logic       we_aligned,
  output logic       access_aligned,
  output llr_t       msg_aligned,
  state_ram_if.addr  ram
);

  logic       [RAM_LATENCY-1:0]              we_d;
  logic       [RAM_LATENCY-1:0]              acc_d;
  logic       [CALC_LATENCY-1:0]             wb_d;
  llr_t       [RAM_LATENCY-1:0]              msg_d;
  node_addr_t [RAM_LATENCY+CALC_LATENCY-1:0] addr_d;

  // read goes straight to the RAM
  assign ram.rd_addr = node_addr;

  // ----------------------------------------------------------------------
  // strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk, posedge rst)
  begin
    if (rst)
    begin
      we_d  <= '0;
      acc_d <= '0;
      wb_d  <= '0;
    end
    else
    begin
      we_d  <= {we_d[RAM_LATENCY-2:0], cn_we};
      acc_d <= {acc_d[RAM_LATENCY-2:0], cn_we | cn_rd};
      // every access writes its record back, reads included
      wb_d  <= {wb_d[CALC_LATENCY-2:0], acc_d[RAM_LATENCY-1]};
    end
  end

  // message and address
  always_ff @(posedge clk)
  begin
    msg_d  <= {msg_d[RAM_LATENCY-2:0], sh_msg};
    addr_d <= {addr_d[RAM_LATENCY+CALC_LATENCY-2:0], node_addr};
  end

  assign we_aligned     = we_d[RAM_LATENCY-1];
  assign access_aligned = acc_d[RAM_LATENCY-1];
  assign msg_aligned    = msg_d[RAM_LATENCY-1];

  assign ram.wr_en   = wb_d[CALC_LATENCY-1];
  assign ram.wr_addr = addr_d[RAM_LATENCY+CALC_LATENCY-1];

endmodule

/* verilog/node_state_ram.sv */
// node record store with a registered address and a registered read word
// read data follows the address by two cycles and the contents start undefined
// clear writes a zero record and wins over a pipeline write in the same cycle
module node_state_ram
  import cn_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       node_clear,
  input  node_addr_t node_clear_addr,
  state_ram_if.ram   ram
);

  logic [STATE_WIDTH-1:0] mem [NODE_COUNT];
  node_addr_t             rd_addr_q;
  cn_state_u              rd_word;

  // storage and address register
  always_ff @(posedge clk)
  begin
    rd_addr_q <= ram.rd_addr;
    if (node_clear)
      mem[node_clear_addr] <= '0;
    else if (ram.wr_en)
      mem[ram.wr_addr] <= ram.wr_data.raw;
  end

  // output register
  always_ff @(posedge clk, posedge rst)
  begin
    if (rst)
      rd_word.raw <= '0;
    else
      rd_word.raw <= mem[rd_addr_q];
  end

  assign ram.rd_data = rd_word;

endmodule

/* verilog/state_ram_if.sv */
// state RAM port bundle between the check-node pipeline and the record store
// no handshake, every access is a single-cycle strobe
interface state_ram_if
  import cn_pkg::*;
();

  node_addr_t rd_addr;
  logic       wr_en;
  node_addr_t wr_addr;
  cn_state_u  wr_data;
  cn_state_u  rd_data;

  modport ram (input rd_addr, input wr_en, input wr_addr, input wr_data, output rd_data);

  // address side lives in the access pipe
  modport addr (output rd_addr, output wr_en, output wr_addr);

  modport wdata (output wr_data);
  modport rdata (input rd_data);

endinterface

/* verilog/cn_pkg.sv */
// widths, latencies and the node record layout shared by the check-node pipeline
// messages are sign-magnitude ones'-complement and a node holds at most 30 edges
package cn_pkg;

  localparam int LLR_WIDTH       = 6;
  localparam int MAG_WIDTH       = LLR_WIDTH - 1;
  localparam int NODE_COUNT      = 128;
  localparam int NODE_ADDR_WIDTH = $clog2(NODE_COUNT);
  localparam int MAX_DEGREE      = 30;
  localparam int POS_WIDTH       = 5;

  // read latency of the state RAM, then cycles from aligned data to write-back
  localparam int RAM_LATENCY     = 2;
  localparam int CALC_LATENCY    = 3;

  typedef logic [LLR_WIDTH-1:0]       llr_t;
  typedef logic [MAG_WIDTH-1:0]       mag_t;
  typedef logic [NODE_ADDR_WIDTH-1:0] node_addr_t;
  typedef logic [POS_WIDTH-1:0]       pos_t;
  typedef logic [MAX_DEGREE-1:0]      sign_vec_t;

  // ----------------------------------------------------------------------
  // one check-node record as stored in the state RAM
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic      iter;
    logic      up;
    pos_t      leastpos;
    pos_t      last_leastpos;
    pos_t      count;
    mag_t      least;
    mag_t      nextleast;
    mag_t      last_least;
    mag_t      last_nextleast;
    logic      sign_result;
    logic      last_sign_result;
    sign_vec_t signs;
  } cn_state_t;

  localparam int STATE_WIDTH = $bits(cn_state_t);

  // RAM side sees the flat word, pipeline side the decoded fields
  typedef union packed {
    logic [STATE_WIDTH-1:0] raw;
    cn_state_t              rec;
  } cn_state_u;

endpackage
